// ==== build.f ====
ex_pkg.sv
alu.sv
mul_unit.sv
div_unit.sv
ex_dispatch.sv
result_fifo.sv
exec_unit.sv
tb_clk_gen.sv
tb_exec_unit.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_exec_unit
RTL_TOP   ?= exec_unit
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall --timing
FAIL_MSG  ?= Done: errors found
PASS_MSG  ?= Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failures"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_exec_unit.sv ====
`timescale 1ns/100ps

module tb_exec_unit import ex_pkg::*; ();

  localparam int alu_reps   = 8;
  localparam int md_reps    = 6;
  localparam int mix_ops    = 40;
  localparam int flush_ops  = 12;
  localparam int total_ops  = 22 * alu_reps + 8 * md_reps + 8 + mix_ops + flush_ops;
  localparam int max_cycles = total_ops * (md_cycles + 10) + 1000;

  logic             clk;
  logic             rst_n;
  logic             flush_i;
  logic             in_valid_i;
  logic             in_ready_o;
  logic             in_is_md_i;
  alu_op_t          in_alu_op_i;
  md_op_t           in_md_op_i;
  logic [xlen-1:0]  src1_i;
  logic [xlen-1:0]  src2_i;
  logic [tag_w-1:0] in_tag_i;
  logic             out_valid_o;
  logic             out_ready_i;
  logic [xlen-1:0]  out_result_o;
  logic [tag_w-1:0] out_tag_o;

  // expected results in acceptance order, tag above result
  logic [tag_w+xlen-1:0] exp_q[$];
  logic [tag_w+xlen-1:0] exp_head;
  logic [tag_w+xlen-1:0] obs;
  logic                  exp_have;
  logic                  obs_xfer;
  logic [31:0]           stim_lfsr;
  logic [31:0]           bp_lfsr;
  logic [1:0]            out_mode;
  logic [tag_w-1:0]      next_tag;
  alu_op_t               alu_ops [11];
  string                 test_name;
  int                    errors;
  int                    checks;
  int                    ops;
  int                    tests;
  int                    cycles;
  int                    test_ops0;
  int                    test_errs0;

  tb_clk_gen clk_gen_inst (.clk_o(clk), .rst_n_o(rst_n));

  exec_unit exec_unit_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush_i      (flush_i),
    .in_valid_i   (in_valid_i),
    .in_ready_o   (in_ready_o),
    .in_is_md_i   (in_is_md_i),
    .in_alu_op_i  (in_alu_op_i),
    .in_md_op_i   (in_md_op_i),
    .src1_i       (src1_i),
    .src2_i       (src2_i),
    .in_tag_i     (in_tag_i),
    .out_valid_o  (out_valid_o),
    .out_ready_i  (out_ready_i),
    .out_result_o (out_result_o),
    .out_tag_o    (out_tag_o)
  );

  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [63:0] stim_take(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[62:0], stim_lfsr[0]};
      stim_lfsr = lfsr_next(stim_lfsr);
    end
    return v;
  endfunction

  // edge values mixed with random ones
  function automatic logic [xlen-1:0] pick_operand();
    logic [2:0] kind;
    logic [1:0] amt;
    kind = 3'(stim_take(3));
    amt  = 2'(stim_take(2));
    case (kind)
      3'd0:    return '0;
      3'd1:    return '1;
      3'd2:    return {1'b1, {(xlen-1){1'b0}}};
      3'd3:    return {1'b0, {(xlen-1){1'b1}}};
      3'd4:    return (amt == 2'd0) ? 64'd0 : (amt == 2'd1) ? 64'd31 :
                      (amt == 2'd2) ? 64'd32 : 64'd63;
      3'd5:    return 64'hffff_ffff_8000_0000;
      default: return stim_take(64);
    endcase
  endfunction

  // word forms work on the low word and sign-extend bit 31
  function automatic logic [xlen-1:0] ref_alu(input alu_op_t op, input logic [xlen-1:0] a,
                                              input logic [xlen-1:0] b);
    logic            word;
    logic [5:0]      sh;
    logic [xlen-1:0] sa;
    logic [xlen-1:0] r;
    word = op[alu_word_bit];
    sh   = word ? {1'b0, b[4:0]} : b[5:0];
    sa   = a;
    if (word) begin
      sa = ({1'b0, op[3:0]} == alu_sra) ? {{32{a[31]}}, a[31:0]} : {32'b0, a[31:0]};
    end
    case ({1'b0, op[3:0]})
      alu_add:  r = a + b;
      alu_sub:  r = a - b;
      alu_sll:  r = sa << sh;
      alu_slt:  r = {63'b0, $signed(a) < $signed(b)};
      alu_sltu: r = {63'b0, a < b};
      alu_pass: r = b;
      alu_xor:  r = a ^ b;
      alu_srl:  r = sa >> sh;
      alu_sra:  r = $signed(sa) >>> sh;
      alu_or:   r = a | b;
      default:  r = a & b;
    endcase
    return word ? {{32{r[31]}}, r[31:0]} : r;
  endfunction

  function automatic logic [xlen-1:0] ref_md(input md_op_t op, input logic [xlen-1:0] a,
                                             input logic [xlen-1:0] b);
    logic [2*xlen-1:0] sxa;
    logic [2*xlen-1:0] sxb;
    logic [2*xlen-1:0] zxa;
    logic [2*xlen-1:0] zxb;
    logic [2*xlen-1:0] prod;
    logic              is_signed;
    logic              want_rem;
    sxa = {{xlen{a[xlen-1]}}, a};
    sxb = {{xlen{b[xlen-1]}}, b};
    zxa = {{xlen{1'b0}}, a};
    zxb = {{xlen{1'b0}}, b};
    is_signed = (op == md_div) || (op == md_rem);
    want_rem  = (op == md_rem) || (op == md_remu);
    case (op)
      md_mulh:   prod = sxa * sxb;
      md_mulhsu: prod = sxa * zxb;
      default:   prod = zxa * zxb;
    endcase
    if (op == md_mul) return prod[xlen-1:0];
    if (op == md_mulh || op == md_mulhsu || op == md_mulhu) return prod[2*xlen-1:xlen];
    if (b == '0) return want_rem ? a : '1;
    if (is_signed && a == {1'b1, {(xlen-1){1'b0}}} && b == '1) return want_rem ? '0 : a;
    if (is_signed) return want_rem ? $signed(a) % $signed(b) : $signed(a) / $signed(b);
    return want_rem ? a % b : a / b;
  endfunction

  task automatic send_op(input logic is_md, input alu_op_t aop, input md_op_t mop,
                         input logic [xlen-1:0] a, input logic [xlen-1:0] b);
    logic [xlen-1:0] want;
    int              gap;
    gap = int'(stim_take(2));
    repeat (gap) @(posedge clk);
    @(posedge clk);
    in_valid_i  <= 1'b1;
    in_is_md_i  <= is_md;
    in_alu_op_i <= aop;
    in_md_op_i  <= mop;
    src1_i      <= a;
    src2_i      <= b;
    in_tag_i    <= next_tag;
    @(negedge clk);
    while (!in_ready_o) @(negedge clk);
    want = is_md ? ref_md(mop, a, b) : ref_alu(aop, a, b);
    @(posedge clk);
    exp_q.push_back({next_tag, want});
    in_valid_i <= 1'b0;
    next_tag = next_tag + tag_w'(1);
    ops++;
  endtask

  task automatic wait_drain();
    @(negedge clk);
    while (exp_q.size() != 0) @(negedge clk);
    repeat (2) @(negedge clk);
  endtask

  task automatic start_test(input string name);
    test_name  = name;
    test_ops0  = ops;
    test_errs0 = errors;
  endtask

  task automatic end_test();
    wait_drain();
    tests++;
    $display("test %s: %0d ops, %0d errors", test_name, ops - test_ops0, errors - test_errs0);
  endtask

  // outputs are stable at the falling edge, the transfer lands on the next rising edge
  always @(negedge clk) begin
    obs_xfer = rst_n && out_valid_o && out_ready_i;
    obs      = {out_tag_o, out_result_o};
    exp_have = (exp_q.size() != 0);
    if (obs_xfer) begin
      checks++;
      if (exp_have) exp_head = exp_q.pop_front();
    end
  end

  a_out_expected: assert property (@(posedge clk) disable iff (!rst_n) obs_xfer |-> exp_have)
    else begin
      errors++;
      $display("result left the unit in test %s with no operation outstanding", test_name);
    end

  a_out_match: assert property (@(posedge clk) disable iff (!rst_n)
    obs_xfer && exp_have |-> obs == exp_head)
    else begin
      errors++;
      $display("error %s: expected tag %0d result %h, actual tag %0d result %h", test_name,
               exp_head[tag_w+xlen-1:xlen], exp_head[xlen-1:0], obs[tag_w+xlen-1:xlen],
               obs[xlen-1:0]);
    end

  a_flush_clears: assert property (@(posedge clk) disable iff (!rst_n)
    flush_i |=> !out_valid_o && in_ready_o)
    else begin
      errors++;
      $display("unit not empty and ready in the cycle after a flush");
    end

  // out_mode 0 keeps out_ready_i high, 1 randomizes it and 2 holds it low
  always @(posedge clk) begin
    if (out_mode == 2'd1) begin
      out_ready_i <= bp_lfsr[0];
      bp_lfsr = lfsr_next(bp_lfsr);
    end else begin
      out_ready_i <= (out_mode == 2'd0);
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > max_cycles) begin
      $display("timeout: run exceeded %0d cycles in test %s", max_cycles, test_name);
      $display("Done: errors found");
      $finish;
    end
  end

  initial begin
    alu_op_t         op;
    md_op_t          mop;
    logic            is_md;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    flush_i     = 1'b0;
    in_valid_i  = 1'b0;
    in_is_md_i  = 1'b0;
    in_alu_op_i = alu_add;
    in_md_op_i  = md_mul;
    src1_i      = '0;
    src2_i      = '0;
    in_tag_i    = '0;
    out_ready_i = 1'b1;
    out_mode    = 2'd0;
    stim_lfsr   = 32'd72568;
    bp_lfsr     = 32'd72568;
    next_tag    = '0;
    obs_xfer    = 1'b0;
    exp_have    = 1'b0;
    errors      = 0;
    checks      = 0;
    ops         = 0;
    tests       = 0;
    cycles      = 0;
    alu_ops = '{alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_pass,
                alu_xor, alu_srl, alu_sra, alu_or, alu_and};

    @(posedge rst_n);
    @(negedge clk);
    start_test("reset");
    assert (!out_valid_o && in_ready_o)
      else begin
        errors++;
        $display("unit not idle in the first cycle after reset");
      end
    end_test();

    start_test("alu");
    for (int w = 0; w < 2; w++) begin
      for (int k = 0; k < 11; k++) begin
        for (int r = 0; r < alu_reps; r++) begin
          op = alu_ops[k];
          op[alu_word_bit] = w[0];
          a = pick_operand();
          b = pick_operand();
          send_op(1'b0, op, md_mul, a, b);
        end
      end
    end
    end_test();

    start_test("mul");
    for (int k = 0; k < 4; k++) begin
      for (int r = 0; r < md_reps; r++) begin
        a = pick_operand();
        b = pick_operand();
        send_op(1'b1, alu_add, md_op_t'(k), a, b);
      end
    end
    end_test();

    // divide by zero and most negative over minus one for each op
    start_test("div");
    for (int k = 4; k < 8; k++) begin
      a = pick_operand();
      send_op(1'b1, alu_add, md_op_t'(k), a, '0);
      send_op(1'b1, alu_add, md_op_t'(k), {1'b1, {(xlen-1){1'b0}}}, '1);
      for (int r = 0; r < md_reps; r++) begin
        a = pick_operand();
        b = pick_operand();
        send_op(1'b1, alu_add, md_op_t'(k), a, b);
      end
    end
    end_test();

    start_test("mixed");
    out_mode = 2'd1;
    for (int i = 0; i < mix_ops; i++) begin
      is_md = (2'(stim_take(2)) == 2'd0);
      op    = alu_ops[int'(stim_take(4)) % 11];
      op[alu_word_bit] = 1'(stim_take(1));
      mop   = md_op_t'(stim_take(3));
      a     = pick_operand();
      b     = pick_operand();
      send_op(is_md, op, mop, a, b);
    end
    end_test();
    out_mode = 2'd0;

    // two results parked in the FIFO, a divide in flight
    start_test("flush");
    out_mode = 2'd2;
    send_op(1'b0, alu_add, md_mul, 64'd5, 64'd7);
    send_op(1'b0, alu_xor, md_mul, 64'h00ff, 64'h0f0f);
    send_op(1'b1, alu_add, md_div, 64'd100, 64'd7);
    repeat (4) @(posedge clk);
    flush_i <= 1'b1;
    @(posedge clk);
    flush_i <= 1'b0;
    exp_q.delete();
    @(negedge clk);
    out_mode = 2'd0;
    for (int i = 0; i < flush_ops - 3; i++) begin
      op  = alu_ops[int'(stim_take(4)) % 11];
      mop = md_op_t'(stim_take(3));
      a   = pick_operand();
      b   = pick_operand();
      send_op(i[0], op, mop, a, b);
    end
    end_test();

    $display("tests %0d, operations %0d, checks %0d, errors %0d", tests, ops, checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/100ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // 10 ns period
  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // reset held for the first 3 rising edges
  initial begin
    rst_n_o = 1'b0;
    repeat (3) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

// ==== exec_unit.sv ====
`timescale 1ns/100ps

module exec_unit import ex_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             flush_i,
  input  logic             in_valid_i,
  output logic             in_ready_o,
  input  logic             in_is_md_i,
  input  alu_op_t          in_alu_op_i,
  input  md_op_t           in_md_op_i,
  input  logic [xlen-1:0]  src1_i,
  input  logic [xlen-1:0]  src2_i,
  input  logic [tag_w-1:0] in_tag_i,
  output logic             out_valid_o,
  input  logic             out_ready_i,
  output logic [xlen-1:0]  out_result_o,
  output logic [tag_w-1:0] out_tag_o
);

  // dispatch to result buffer
  logic             wr_valid;
  logic             wr_ready;
  logic [xlen-1:0]  wr_result;
  logic [tag_w-1:0] wr_tag;

  ex_dispatch dispatch_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (flush_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .in_is_md_i  (in_is_md_i),
    .in_alu_op_i (in_alu_op_i),
    .in_md_op_i  (in_md_op_i),
    .src1_i      (src1_i),
    .src2_i      (src2_i),
    .in_tag_i    (in_tag_i),
    .wr_valid_o  (wr_valid),
    .wr_ready_i  (wr_ready),
    .wr_result_o (wr_result),
    .wr_tag_o    (wr_tag)
  );

  result_fifo fifo_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (flush_i),
    .wr_valid_i  (wr_valid),
    .wr_ready_o  (wr_ready),
    .wr_result_i (wr_result),
    .wr_tag_i    (wr_tag),
    .rd_valid_o  (out_valid_o),
    .rd_ready_i  (out_ready_i),
    .rd_result_o (out_result_o),
    .rd_tag_o    (out_tag_o)
  );

endmodule

// ==== result_fifo.sv ====
`timescale 1ns/100ps

module result_fifo import ex_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             flush_i,
  input  logic             wr_valid_i,
  output logic             wr_ready_o,
  input  logic [xlen-1:0]  wr_result_i,
  input  logic [tag_w-1:0] wr_tag_i,
  output logic             rd_valid_o,
  input  logic             rd_ready_i,
  output logic [xlen-1:0]  rd_result_o,
  output logic [tag_w-1:0] rd_tag_o
);

  logic [xlen-1:0]       result_mem [fifo_depth];
  logic [tag_w-1:0]      tag_mem    [fifo_depth];
  logic [fifo_ptr_w-1:0] wr_ptr_q;
  logic [fifo_ptr_w-1:0] rd_ptr_q;
  logic [fifo_cnt_w-1:0] count_q;
  logic                  push;
  logic                  pop;

  assign wr_ready_o = (count_q != fifo_cnt_w'(fifo_depth));
  assign rd_valid_o = (count_q != '0);
  assign push       = wr_valid_i && wr_ready_o;
  assign pop        = rd_valid_o && rd_ready_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == fifo_ptr_w'(fifo_depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == fifo_ptr_w'(fifo_depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // simultaneous push and pop leave the count alone
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      result_mem[wr_ptr_q] <= wr_result_i;
      tag_mem[wr_ptr_q]    <= wr_tag_i;
    end
  end

  assign rd_result_o = result_mem[rd_ptr_q];
  assign rd_tag_o    = tag_mem[rd_ptr_q];

  // pointers meet only when the buffer is empty or full
  a_count_max: assert property (@(posedge clk) disable iff (!rst_n)
    (count_q <= fifo_cnt_w'(fifo_depth)) &&
    ((wr_ptr_q == rd_ptr_q) == (count_q == '0 || count_q == fifo_cnt_w'(fifo_depth))))
    else $error("result_fifo: count above depth or out of step with the pointers");

endmodule

// ==== ex_dispatch.sv ====
`timescale 1ns/100ps

module ex_dispatch import ex_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             flush_i,
  input  logic             in_valid_i,
  output logic             in_ready_o,
  input  logic             in_is_md_i,
  input  alu_op_t          in_alu_op_i,
  input  md_op_t           in_md_op_i,
  input  logic [xlen-1:0]  src1_i,
  input  logic [xlen-1:0]  src2_i,
  input  logic [tag_w-1:0] in_tag_i,
  output logic             wr_valid_o,
  input  logic             wr_ready_i,
  output logic [xlen-1:0]  wr_result_o,
  output logic [tag_w-1:0] wr_tag_o
);

  logic             accept;
  logic             pend_valid_q;
  logic             md_wait_q;
  logic             md_start_q;
  logic [xlen-1:0]  pend_result_q;
  logic [tag_w-1:0] tag_q;
  md_op_t           md_op_q;
  logic [xlen-1:0]  src1_q;
  logic [xlen-1:0]  src2_q;
  logic [xlen-1:0]  alu_result;
  logic             mul_busy;
  logic             mul_done;
  logic [xlen-1:0]  mul_result;
  logic             div_busy;
  logic             div_done;
  logic [xlen-1:0]  div_result;
  logic             md_done;
  logic [xlen-1:0]  md_result;

  alu alu_inst (
    .op_i     (in_alu_op_i),
    .src1_i   (src1_i),
    .src2_i   (src2_i),
    .result_o (alu_result)
  );

  mul_unit mul_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .flush_i  (flush_i),
    .start_i  (md_start_q && !md_op_q[2]),
    .op_i     (md_op_q),
    .src1_i   (src1_q),
    .src2_i   (src2_q),
    .busy_o   (mul_busy),
    .done_o   (mul_done),
    .result_o (mul_result)
  );

  div_unit div_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .flush_i  (flush_i),
    .start_i  (md_start_q && md_op_q[2]),
    .op_i     (md_op_q),
    .src1_i   (src1_q),
    .src2_i   (src2_q),
    .busy_o   (div_busy),
    .done_o   (div_done),
    .result_o (div_result)
  );

  assign md_done   = mul_done | div_done;
  assign md_result = md_op_q[2] ? div_result : mul_result;

  // one op in flight at a time, nothing taken during a flush
  assign in_ready_o = !flush_i && !pend_valid_q && !md_wait_q && wr_ready_i;
  assign accept     = in_valid_i && in_ready_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pend_valid_q <= 1'b0;
      md_wait_q    <= 1'b0;
      md_start_q   <= 1'b0;
    end else if (flush_i) begin
      pend_valid_q <= 1'b0;
      md_wait_q    <= 1'b0;
      md_start_q   <= 1'b0;
    end else begin
      md_start_q <= accept && in_is_md_i;
      if (accept) begin
        pend_valid_q <= !in_is_md_i;
        md_wait_q    <= in_is_md_i;
      end else if (md_done) begin
        md_wait_q    <= 1'b0;
        // FIFO full at done, park the result
        pend_valid_q <= !wr_ready_i;
      end else if (pend_valid_q && wr_ready_i) begin
        pend_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      tag_q         <= in_tag_i;
      md_op_q       <= in_md_op_i;
      src1_q        <= src1_i;
      src2_q        <= src2_i;
      pend_result_q <= alu_result;
    end else if (md_done) begin
      pend_result_q <= md_result;
    end
  end

  // a done result goes to the FIFO on the same edge
  assign wr_valid_o  = pend_valid_q || md_done;
  assign wr_result_o = pend_valid_q ? pend_result_q : md_result;
  assign wr_tag_o    = tag_q;

  a_wr_hold: assert property (@(posedge clk) disable iff (!rst_n || flush_i)
    wr_valid_o && !wr_ready_i |=> wr_valid_o && $stable(wr_result_o) && $stable(wr_tag_o))
    else $error("ex_dispatch: write request dropped or changed before accept");

  a_units_idle: assert property (@(posedge clk) disable iff (!rst_n)
    !md_wait_q |-> !mul_busy && !div_busy)
    else $error("ex_dispatch: unit busy with no op waiting");

endmodule

// ==== div_unit.sv ====
`timescale 1ns/100ps

module div_unit import ex_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            flush_i,
  input  logic            start_i,
  input  md_op_t          op_i,
  input  logic [xlen-1:0] src1_i,
  input  logic [xlen-1:0] src2_i,
  output logic            busy_o,
  output logic            done_o,
  output logic [xlen-1:0] result_o
);

  logic                busy_q;
  logic [md_cnt_w-1:0] cnt_q;
  logic [xlen-1:0]     dvs_q;
  logic [xlen-1:0]     quo_q;
  logic [xlen-1:0]     rem_q;
  logic                q_neg_q;
  logic                r_neg_q;
  logic                rem_sel_q;
  logic                spec_q;
  logic [xlen-1:0]     spec_res_q;
  logic                is_signed;
  logic                sgn1;
  logic                sgn2;
  logic                div_zero;
  logic                div_ovf;
  logic [xlen-1:0]     spec_res;
  logic [xlen:0]       shifted;
  logic [xlen:0]       diff;
  logic [xlen-1:0]     quo_fix;
  logic [xlen-1:0]     rem_fix;

  // op bit 0 marks unsigned, bit 1 selects the remainder
  assign is_signed = !op_i[0];
  assign sgn1      = is_signed && src1_i[xlen-1];
  assign sgn2      = is_signed && src2_i[xlen-1];

  // corner cases settled up front, result held until the normal latency
  assign div_zero = (src2_i == '0);
  assign div_ovf  = is_signed && (src1_i == {1'b1, {(xlen-1){1'b0}}}) && (&src2_i);
  assign spec_res = div_zero ? (op_i[1] ? src1_i : '1) : (op_i[1] ? '0 : src1_i);

  // bring down the next dividend bit and try the subtract
  assign shifted = {rem_q, quo_q[xlen-1]};
  assign diff    = shifted - {1'b0, dvs_q};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (flush_i) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (start_i) begin
      busy_q <= 1'b1;
      cnt_q  <= '0;
    end else if (done_o) begin
      busy_q <= 1'b0;
    end else if (busy_q) begin
      cnt_q <= cnt_q + md_cnt_w'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (start_i) begin
      dvs_q      <= sgn2 ? -src2_i : src2_i;
      quo_q      <= sgn1 ? -src1_i : src1_i;
      rem_q      <= '0;
      q_neg_q    <= sgn1 ^ sgn2;
      r_neg_q    <= sgn1;
      rem_sel_q  <= op_i[1];
      spec_q     <= div_zero || div_ovf;
      spec_res_q <= spec_res;
    end else if (busy_q && !done_o) begin
      // restore by keeping the shifted value when the subtract goes negative
      if (!diff[xlen]) begin
        rem_q <= diff[xlen-1:0];
        quo_q <= {quo_q[xlen-2:0], 1'b1};
      end else begin
        rem_q <= shifted[xlen-1:0];
        quo_q <= {quo_q[xlen-2:0], 1'b0};
      end
    end
  end

  // remainder takes the sign of the dividend
  assign quo_fix  = q_neg_q ? -quo_q : quo_q;
  assign rem_fix  = r_neg_q ? -rem_q : rem_q;
  assign done_o   = busy_q && (cnt_q == md_cnt_w'(md_cycles));
  assign busy_o   = busy_q;
  assign result_o = spec_q ? spec_res_q : (rem_sel_q ? rem_fix : quo_fix);

  a_no_restart: assert property (@(posedge clk) disable iff (!rst_n) start_i |-> !busy_o)
    else $error("div_unit: start while busy");

endmodule

// ==== mul_unit.sv ====
`timescale 1ns/100ps

module mul_unit import ex_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            flush_i,
  input  logic            start_i,
  input  md_op_t          op_i,
  input  logic [xlen-1:0] src1_i,
  input  logic [xlen-1:0] src2_i,
  output logic            busy_o,
  output logic            done_o,
  output logic [xlen-1:0] result_o
);

  logic                  busy_q;
  logic [md_cnt_w-1:0]   cnt_q;
  logic                  neg_q;
  logic                  high_q;
  logic [xlen-1:0]       mcand_q;
  logic [2*xlen-1:0]     prod_q;
  logic                  sgn1;
  logic                  sgn2;
  logic [xlen-1:0]       mag1;
  logic [xlen-1:0]       mag2;
  logic [xlen:0]         part_sum;
  logic [2*xlen-1:0]     prod_fix;

  // mulh treats both as signed, mulhsu only src1
  assign sgn1 = (op_i[1:0] == 2'd1 || op_i[1:0] == 2'd2) && src1_i[xlen-1];
  assign sgn2 = (op_i[1:0] == 2'd1) && src2_i[xlen-1];
  assign mag1 = sgn1 ? -src1_i : src1_i;
  assign mag2 = sgn2 ? -src2_i : src2_i;

  // multiplier sits in the low half and shifts out one bit per step
  assign part_sum = {1'b0, prod_q[2*xlen-1:xlen]} + (prod_q[0] ? {1'b0, mcand_q} : '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (flush_i) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (start_i) begin
      busy_q <= 1'b1;
      cnt_q  <= '0;
    end else if (done_o) begin
      busy_q <= 1'b0;
    end else if (busy_q) begin
      cnt_q <= cnt_q + md_cnt_w'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (start_i) begin
      mcand_q <= mag1;
      prod_q  <= {{xlen{1'b0}}, mag2};
      neg_q   <= sgn1 ^ sgn2;
      high_q  <= (op_i[1:0] != 2'd0);
    end else if (busy_q && !done_o) begin
      prod_q <= {part_sum, prod_q[xlen-1:1]};
    end
  end

  assign done_o   = busy_q && (cnt_q == md_cnt_w'(md_cycles));
  assign busy_o   = busy_q;
  assign prod_fix = neg_q ? -prod_q : prod_q;
  assign result_o = high_q ? prod_fix[2*xlen-1:xlen] : prod_fix[xlen-1:0];

  // done ends the busy phase
  a_done_busy: assert property (@(posedge clk) disable iff (!rst_n) done_o |=> !busy_o)
    else $error("mul_unit: still busy after done");

endmodule

// ==== alu.sv ====
`timescale 1ns/100ps

module alu import ex_pkg::*; (
  input  alu_op_t         op_i,
  input  logic [xlen-1:0] src1_i,
  input  logic [xlen-1:0] src2_i,
  output logic [xlen-1:0] result_o
);

  logic            word;
  logic            cin;
  logic            unsigned_cmp;
  logic            shift_right;
  logic            shift_arith;
  logic [xlen-1:0] add_b;
  logic [xlen-1:0] add_sum;
  logic            carry;
  logic            overflow;
  logic            less;
  logic [5:0]      shamt;
  logic [xlen-1:0] sh_in;
  logic [xlen-1:0] sh_src;
  logic [xlen:0]   sh_ext;
  logic [xlen-1:0] sh_raw;
  logic [xlen-1:0] shift_res;
  logic [xlen-1:0] alu_out;

  // decode straight from the op bits
  assign word         = op_i[alu_word_bit];
  assign cin          = op_i[1] | op_i[3];
  assign unsigned_cmp = op_i[3];
  assign shift_right  = op_i[2];
  assign shift_arith  = op_i[3];

  // one adder for add, sub and both compares
  assign add_b = src2_i ^ {xlen{cin}};
  assign {carry, add_sum} = {1'b0, src1_i} + {1'b0, add_b} + {{xlen{1'b0}}, cin};
  assign overflow = (src1_i[xlen-1] == add_b[xlen-1]) && (add_sum[xlen-1] != src1_i[xlen-1]);

  // unsigned less is a missing carry out of a - b
  assign less = unsigned_cmp ? (carry ^ cin) : (add_sum[xlen-1] ^ overflow);

  // word shifts see only the low word and 5 shift bits
  assign shamt = word ? {1'b0, src2_i[4:0]} : src2_i[5:0];
  assign sh_in = word ? {{32{shift_arith & src1_i[31]}}, src1_i[31:0]} : src1_i;

  // left shift runs through the right shifter on reversed bits
  always_comb begin
    for (int i = 0; i < xlen; i++) begin
      sh_src[i] = shift_right ? sh_in[i] : sh_in[xlen-1-i];
    end
  end

  assign sh_ext = {shift_right & shift_arith & sh_src[xlen-1], sh_src};
  assign sh_raw = sh_ext[xlen-1:0] >> shamt | ~({xlen{1'b1}} >> shamt) & {xlen{sh_ext[xlen]}};

  always_comb begin
    for (int i = 0; i < xlen; i++) begin
      shift_res[i] = shift_right ? sh_raw[i] : sh_raw[xlen-1-i];
    end
  end

  always_comb begin
    case (op_i[2:0])
      3'h0:      alu_out = add_sum;
      3'h1, 3'h5: alu_out = shift_res;
      3'h2:      alu_out = {{(xlen-1){1'b0}}, less};
      3'h3:      alu_out = src2_i;
      3'h4:      alu_out = src1_i ^ src2_i;
      3'h6:      alu_out = src1_i | src2_i;
      default:   alu_out = src1_i & src2_i;
    endcase
  end

  assign result_o = word ? {{32{alu_out[31]}}, alu_out[31:0]} : alu_out;

endmodule

// ==== ex_pkg.sv ====
package ex_pkg;

  // datapath and tag widths
  localparam int xlen  = 64;
  localparam int tag_w = 4;

  // result buffer sizing
  localparam int fifo_depth = 4;
  localparam int fifo_ptr_w = $clog2(fifo_depth);
  localparam int fifo_cnt_w = $clog2(fifo_depth + 1);

  // iterative mul/div units, one bit per cycle
  localparam int md_cycles = 64;
  localparam int md_cnt_w  = $clog2(md_cycles + 1);

  typedef logic [4:0] alu_op_t;
  typedef logic [2:0] md_op_t;

  // bit 4 selects the 32-bit word form, result sign-extended
  localparam int alu_word_bit = 4;

  // in the low bits [3] picks the variant and [2:0] the result source
  localparam alu_op_t alu_add  = 5'b0_0000;
  localparam alu_op_t alu_sub  = 5'b0_1000;
  localparam alu_op_t alu_sll  = 5'b0_0001;
  localparam alu_op_t alu_slt  = 5'b0_0010;
  localparam alu_op_t alu_sltu = 5'b0_1010;
  localparam alu_op_t alu_pass = 5'b0_0011;
  localparam alu_op_t alu_xor  = 5'b0_0100;
  localparam alu_op_t alu_srl  = 5'b0_0101;
  localparam alu_op_t alu_sra  = 5'b0_1101;
  localparam alu_op_t alu_or   = 5'b0_0110;
  localparam alu_op_t alu_and  = 5'b0_0111;

  // bit 2 set selects the divider
  localparam md_op_t md_mul    = 3'd0;
  localparam md_op_t md_mulh   = 3'd1;
  localparam md_op_t md_mulhsu = 3'd2;
  localparam md_op_t md_mulhu  = 3'd3;
  localparam md_op_t md_div    = 3'd4;
  localparam md_op_t md_divu   = 3'd5;
  localparam md_op_t md_rem    = 3'd6;
  localparam md_op_t md_remu   = 3'd7;

endpackage
